/* tgen_consts.svh */
`ifndef TGEN_CONSTS_SVH
`define TGEN_CONSTS_SVH

// Width of the host and downstream bus address
`define TGEN_AW 17

// Program counter width
// 15 bits give 32768 words per bank
`define TGEN_PCW 15

// Delay granularity exponent
// Each delay unit lasts 2**TGEN_GRAN clock cycles
`define TGEN_GRAN 0

// Width of the saturating collision counter
`define TGEN_CW 8

`endif

/* tgen_pkg.sv */
`default_nettype none

`include "tgen_consts.svh"

package tgen_pkg;

	// Downstream and host bus payload
	typedef logic [31:0] lb_data_t;
	typedef logic [`TGEN_AW-1:0] lb_addr_t;

	// One program memory word
	typedef logic [15:0] word_t;

	// Program counter, low two bits select the word within an entry
	typedef logic [`TGEN_PCW-1:0] pc_t;

	// Bank bit on top of the program counter
	typedef logic [`TGEN_PCW:0] ram_addr_t;

	// Delay count after scaling by the granularity
	typedef logic [15+`TGEN_GRAN:0] timer_t;

	// Monitor word
	// work of previous run, previous bank, current bank, bank_next
	typedef logic [3:0] status_t;

	typedef logic [`TGEN_CW-1:0] coll_count_t;

	// Sequencer states
	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		WAIT
	} seq_state_t;

endpackage

`default_nettype wire

/* program_ram.sv */
`default_nettype none

`include "tgen_consts.svh"

// Two-bank program store
// Host fills one bank while the sequencer plays the other one
module program_ram (
	input  logic                clk,
	input  tgen_pkg::ram_addr_t wr_addr,
	input  tgen_pkg::word_t     wr_data,
	input  logic                wr_en,
	input  tgen_pkg::ram_addr_t rd_addr,
	output tgen_pkg::word_t     rd_data
);

	// Both banks in one array, bank bit is the top address bit
	localparam int mem_depth = 2 ** (`TGEN_PCW + 1);

	tgen_pkg::word_t mem [mem_depth];

	// Host write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Sequencer read port
	// One cycle of registered latency, maps onto block RAM
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

	// Ports normally sit in opposite banks
	// A host write to the running bank only happens right at a bank flip
	// and read-during-write returns the old word there

endmodule

`default_nettype wire

/* tgen_sequencer.sv */
`default_nettype none

`include "tgen_consts.svh"

// Program sequencer
// Walks the active bank four words per entry
// delay, address, data low, data high
// and issues one register write per entry
module tgen_sequencer (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                trig,
	input  logic                bank_next,
	input  logic [`TGEN_AW-17:0] addr_padding,
	input  tgen_pkg::word_t     rd_data,
	output tgen_pkg::ram_addr_t rd_addr,
	output logic                bank,
	output logic                gen_write,
	output tgen_pkg::lb_addr_t  gen_addr,
	output tgen_pkg::lb_data_t  gen_data,
	output tgen_pkg::status_t   status
);

	tgen_pkg::seq_state_t state;
	tgen_pkg::pc_t        pc;
	tgen_pkg::timer_t     timer;
	logic [1:0]           subcycle;
	logic                 start;
	logic                 addr_zero;
	logic                 did_work;
	logic                 work_prev;
	logic                 bank_prev;

	// Delayed read words for entry assembly
	tgen_pkg::word_t word_q1;
	tgen_pkg::word_t word_q2;

	assign subcycle = pc[1:0];

	// Trigger only counts while idle, later ones are dropped
	assign start = trig && (state == tgen_pkg::IDLE);

	// At subcycle 3 word_q1 holds the address word of the entry
	assign addr_zero = (word_q1 == '0);

	// Sequencer reads the bank the host is not writing
	assign rd_addr = {~bank, pc};

	// Main FSM and program counter
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= tgen_pkg::IDLE;
			pc <= '0;
		end else begin
			case (state)
				tgen_pkg::IDLE: begin
					// pc holds at 0, first read of word 0 happens next cycle
					if (trig) begin
						state <= tgen_pkg::FETCH;
					end
				end
				tgen_pkg::FETCH: begin
					if (subcycle == 2'd3 && addr_zero) begin
						// Zero address ends the program
						pc <= '0;
						state <= tgen_pkg::IDLE;
					end else begin
						pc <= pc + 1'b1;
						if (subcycle == 2'd3) begin
							state <= tgen_pkg::WAIT;
						end
					end
				end
				tgen_pkg::WAIT: begin
					// Sit on word 0 of the next entry until the delay runs out
					if (timer == '0) begin
						pc <= pc + 1'b1;
						state <= tgen_pkg::FETCH;
					end
				end
				default: begin
					state <= tgen_pkg::IDLE;
				end
			endcase
		end
	end

	// Delay timer
	// Loaded while the delay word is on rd_data, counted down in WAIT
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			timer <= '0;
		end else if (state == tgen_pkg::FETCH && subcycle == 2'd1) begin
			timer <= tgen_pkg::timer_t'(rd_data) << `TGEN_GRAN;
		end else if (state == tgen_pkg::WAIT && timer != '0) begin
			timer <= timer - 1'b1;
		end
	end

	// Bank flip happens atomically at the trigger
	// bank_next may come from elsewhere, it is only looked at here
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bank <= 1'b0;
			bank_prev <= 1'b0;
			work_prev <= 1'b0;
			did_work <= 1'b0;
		end else begin
			if (start) begin
				bank <= bank_next;
				bank_prev <= bank;
				work_prev <= did_work;
				did_work <= 1'b0;
			end else if (gen_write) begin
				did_work <= 1'b1;
			end
		end
	end

	// Read data pipeline, payload only
	always_ff @(posedge clk) begin
		word_q1 <= rd_data;
		word_q2 <= word_q1;
	end

	// Write strobe lands on the first cycle of WAIT
	// by then the high word is on rd_data
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gen_write <= 1'b0;
		end else begin
			gen_write <= (state == tgen_pkg::FETCH) && (subcycle == 2'd3) && !addr_zero;
		end
	end

	// Entry assembly
	// word_q2 address, word_q1 low half, rd_data high half
	assign gen_addr = {addr_padding, word_q2};
	assign gen_data = {rd_data, word_q1};

	assign status = {work_prev, bank_prev, bank, bank_next};

	// Write strobe is one cycle behind the FSM, still never idle
	a_no_write_idle: assert property (
		@(posedge clk) disable iff (!arst_n)
		gen_write |-> (state != tgen_pkg::IDLE)
	);

	// Every path into IDLE clears pc
	a_idle_pc_zero: assert property (
		@(posedge clk) disable iff (!arst_n)
		(state == tgen_pkg::IDLE) |-> (pc == '0)
	);

endmodule

`default_nettype wire

/* bus_merge.sv */
`default_nettype none

// Downstream bus merge
// One register stage, host writes beat generator writes
module bus_merge (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  lb_write,
	input  logic                  dests_write,
	input  tgen_pkg::lb_addr_t    lb_addr,
	input  tgen_pkg::lb_data_t    lb_data,
	input  logic                  gen_write,
	input  tgen_pkg::lb_addr_t    gen_addr,
	input  tgen_pkg::lb_data_t    gen_data,
	output logic                  lbo_write,
	output tgen_pkg::lb_addr_t    lbo_addr,
	output tgen_pkg::lb_data_t    lbo_data,
	output logic                  collision,
	output tgen_pkg::coll_count_t collision_count
);

	logic write_thru;
	logic clash;

	// Program memory writes stay local
	assign write_thru = lb_write && !dests_write;

	// Generator write lost to the host
	assign clash = write_thru && gen_write;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lbo_write <= 1'b0;
			lbo_addr <= '0;
			lbo_data <= '0;
			collision <= 1'b0;
		end else begin
			lbo_write <= write_thru || gen_write;
			lbo_addr <= write_thru ? lb_addr : gen_addr;
			lbo_data <= write_thru ? lb_data : gen_data;
			collision <= clash;
		end
	end

	// Saturating count of lost writes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			collision_count <= '0;
		end else if (clash && collision_count != '1) begin
			collision_count <= collision_count + 1'b1;
		end
	end

	// A lost write always leaves a host write on the bus
	a_coll_write: assert property (
		@(posedge clk) disable iff (!arst_n)
		collision |-> lbo_write
	);

	// Generator strobes are at least four cycles apart
	a_coll_pulse: assert property (
		@(posedge clk) disable iff (!arst_n)
		collision |=> !collision
	);

endmodule

`default_nettype wire

/* tgen_top.sv */
`default_nettype none

`include "tgen_consts.svh"

// Timing generator top level
// Sits in a local write bus, passes host writes through
// and plays a stored register-write program on each trigger
module tgen_top (
	input  logic                  clk,
	input  logic                  arst_n,
	// Host bus
	input  tgen_pkg::lb_data_t    lb_data,
	input  tgen_pkg::lb_addr_t    lb_addr,
	input  logic                  lb_write,
	input  logic                  dests_write,
	// High address bits for program writes
	input  logic [`TGEN_AW-17:0]  addr_padding,
	input  logic                  trig,
	input  logic                  bank_next,
	// Downstream bus
	output tgen_pkg::lb_data_t    lbo_data,
	output tgen_pkg::lb_addr_t    lbo_addr,
	output logic                  lbo_write,
	// Monitoring
	output logic                  collision,
	output tgen_pkg::coll_count_t collision_count,
	output tgen_pkg::status_t     status
);

	tgen_pkg::ram_addr_t wr_addr;
	tgen_pkg::ram_addr_t rd_addr;
	tgen_pkg::word_t     rd_data;
	logic                bank;
	logic                gen_write;
	tgen_pkg::lb_addr_t  gen_addr;
	tgen_pkg::lb_data_t  gen_data;

	// Host fills the current bank, sequencer plays the other
	assign wr_addr = {bank, lb_addr[`TGEN_PCW-1:0]};

	program_ram program_ram_inst (
		.clk     (clk),
		.wr_addr (wr_addr),
		.wr_data (lb_data[15:0]),
		.wr_en   (dests_write),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	tgen_sequencer tgen_sequencer_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.trig         (trig),
		.bank_next    (bank_next),
		.addr_padding (addr_padding),
		.rd_data      (rd_data),
		.rd_addr      (rd_addr),
		.bank         (bank),
		.gen_write    (gen_write),
		.gen_addr     (gen_addr),
		.gen_data     (gen_data),
		.status       (status)
	);

	// Single cycle from host bus to downstream bus
	bus_merge bus_merge_inst (
		.clk             (clk),
		.arst_n          (arst_n),
		.lb_write        (lb_write),
		.dests_write     (dests_write),
		.lb_addr         (lb_addr),
		.lb_data         (lb_data),
		.gen_write       (gen_write),
		.gen_addr        (gen_addr),
		.gen_data        (gen_data),
		.lbo_write       (lbo_write),
		.lbo_addr        (lbo_addr),
		.lbo_data        (lbo_data),
		.collision       (collision),
		.collision_count (collision_count)
	);

endmodule

`default_nettype wire

/* tgen_tb.sv */
`default_nettype none

`include "tgen_consts.svh"

module tgen_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// Row kinds of the stimulus table
	localparam int op_host = 0;
	localparam int op_dest = 1;
	localparam int op_entry = 2;
	localparam int op_trig = 3;
	localparam int op_retrig = 4;
	localparam int op_clash = 5;
	localparam int op_check = 6;

	// Quiet cycles after a run that must stay free of writes
	localparam int idle_wait = 32;

	typedef struct packed {
		int                    kind;
		tgen_pkg::lb_addr_t    addr;
		tgen_pkg::lb_data_t    data;
		int                    delay;
		tgen_pkg::status_t     exp_status;
		tgen_pkg::coll_count_t exp_count;
	} row_t;

	logic                  clk;
	logic                  arst_n;
	tgen_pkg::lb_data_t    lb_data;
	tgen_pkg::lb_addr_t    lb_addr;
	logic                  lb_write;
	logic                  dests_write;
	logic [`TGEN_AW-17:0]  addr_padding;
	logic                  trig;
	logic                  bank_next;
	tgen_pkg::lb_data_t    lbo_data;
	tgen_pkg::lb_addr_t    lbo_addr;
	logic                  lbo_write;
	logic                  collision;
	tgen_pkg::coll_count_t collision_count;
	tgen_pkg::status_t     status;

	row_t rows[$];
	int   seed;
	int   errors;
	int   wd_cycles;
	int   cyc;
	int   load_idx;
	int   model_bank;
	int   clash_n;
	int   coll_seen;

	// Program model with one set of entries per bank
	tgen_pkg::word_t    ent_addr [2][8];
	tgen_pkg::lb_data_t ent_data [2][8];
	int                 ent_delay [2][8];
	int                 prog_len [2];

	// Writes expected from the running bank and writes seen downstream
	tgen_pkg::lb_addr_t exp_addr[$];
	tgen_pkg::lb_data_t exp_data[$];
	int                 exp_delay[$];
	tgen_pkg::lb_addr_t got_addr[$];
	tgen_pkg::lb_data_t got_data[$];
	int                 got_cyc[$];

	tgen_top tgen_top_inst (
		.clk             (clk),
		.arst_n          (arst_n),
		.lb_data         (lb_data),
		.lb_addr         (lb_addr),
		.lb_write        (lb_write),
		.dests_write     (dests_write),
		.addr_padding    (addr_padding),
		.trig            (trig),
		.bank_next       (bank_next),
		.lbo_data        (lbo_data),
		.lbo_addr        (lbo_addr),
		.lbo_write       (lbo_write),
		.collision       (collision),
		.collision_count (collision_count),
		.status          (status)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Downstream monitor samples on the falling edge where outputs are settled
	always @(negedge clk) begin
		cyc++;
		if (lbo_write === 1'b1) begin
			got_addr.push_back(lbo_addr);
			got_data.push_back(lbo_data);
			got_cyc.push_back(cyc);
		end
		if (collision === 1'b1) begin
			coll_seen++;
		end
	end

	task automatic check_write(input tgen_pkg::lb_addr_t got_a, input tgen_pkg::lb_data_t got_d,
			input tgen_pkg::lb_addr_t exp_a, input tgen_pkg::lb_data_t exp_d);
		if (got_a !== exp_a || got_d !== exp_d) begin
			$display("Mismatch at %0t: write %h <= %h, expected %h <= %h",
				$time, got_a, got_d, exp_a, exp_d);
			errors++;
		end
	endtask

	task automatic check_count(input tgen_pkg::coll_count_t got, input tgen_pkg::coll_count_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: collision_count %0d, expected %0d", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_status(input tgen_pkg::status_t got, input tgen_pkg::status_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: status %b, expected %b", $time, got, exp);
			errors++;
		end
	endtask

	// One host bus cycle with dest selecting the program memory
	task automatic bus_write(input tgen_pkg::lb_addr_t addr, input tgen_pkg::lb_data_t data,
			input logic dest);
		@(posedge clk);
		lb_write <= 1'b1;
		dests_write <= dest;
		lb_addr <= addr;
		lb_data <= data;
		@(posedge clk);
		lb_write <= 1'b0;
		dests_write <= 1'b0;
	endtask

	// Pass-through shows up one cycle later and program memory writes never do
	task automatic host_write(input row_t r, input logic dest);
		bus_write(r.addr, r.data, dest);
		@(negedge clk);
		if (lbo_write !== !dest) begin
			$display("Mismatch at %0t: lbo_write %b in the cycle after a host write, expected %b",
				$time, lbo_write, !dest);
			errors++;
		end else if (!dest) begin
			check_write(lbo_addr, lbo_data, r.addr, r.data);
		end
		@(negedge clk);
		if (lbo_write !== 1'b0) begin
			$display("Mismatch at %0t: lbo_write %b two cycles after a host write, expected 0",
				$time, lbo_write);
			errors++;
		end
	endtask

	// Entry words in order delay, address, data low, data high
	task automatic load_entry(input row_t r);
		tgen_pkg::lb_data_t rnd;
		tgen_pkg::word_t    words [4];
		tgen_pkg::lb_addr_t wa;
		int                 w;
		rnd = $random(seed);
		words[0] = tgen_pkg::word_t'(r.delay);
		words[1] = r.addr[15:0];
		words[2] = rnd[15:0];
		words[3] = rnd[31:16];
		for (w = 0; w < 4; w++) begin
			wa = tgen_pkg::lb_addr_t'(load_idx * 4 + w);
			bus_write(wa, {16'h0, words[w]}, 1'b1);
		end
		ent_addr[model_bank][load_idx] = r.addr[15:0];
		ent_data[model_bank][load_idx] = rnd;
		ent_delay[model_bank][load_idx] = r.delay;
		// Zero address closes the program
		if (r.addr[15:0] == 16'h0) begin
			prog_len[model_bank] = load_idx;
			load_idx = 0;
		end else begin
			load_idx++;
		end
	endtask

	task automatic start_run(input row_t r);
		int pb;
		int i;
		@(posedge clk);
		trig <= 1'b1;
		bank_next <= r.data[0];
		model_bank = r.data[0];
		// Sequencer plays the bank the host does not own
		pb = 1 - model_bank;
		exp_addr.delete();
		exp_data.delete();
		exp_delay.delete();
		got_addr.delete();
		got_data.delete();
		got_cyc.delete();
		coll_seen = 0;
		clash_n = 0;
		for (i = 0; i < prog_len[pb]; i++) begin
			exp_addr.push_back({addr_padding, ent_addr[pb][i]});
			exp_data.push_back(ent_data[pb][i]);
			exp_delay.push_back(ent_delay[pb][i]);
		end
		@(posedge clk);
		trig <= 1'b0;
		@(negedge clk);
		check_status(status, r.exp_status);
	endtask

	// Trigger with a flipped bank_next while busy is ignored
	task automatic retrigger_during_run(input row_t r);
		@(posedge clk);
		trig <= 1'b1;
		bank_next <= ~bank_next;
		@(posedge clk);
		trig <= 1'b0;
		bank_next <= (model_bank != 0);
		@(negedge clk);
		check_status(status, r.exp_status);
	endtask

	// Host write placed on the cycle of the second generator strobe
	task automatic clash_second_write(input row_t r);
		int gap;
		gap = 4 + (exp_delay[0] << `TGEN_GRAN);
		@(negedge clk);
		while (lbo_write !== 1'b1) begin
			@(negedge clk);
		end
		repeat (gap - 1) @(posedge clk);
		lb_write <= 1'b1;
		lb_addr <= r.addr;
		lb_data <= r.data;
		@(posedge clk);
		lb_write <= 1'b0;
		exp_addr[1] = r.addr;
		exp_data[1] = r.data;
		clash_n++;
	endtask

	task automatic check_run(input row_t r);
		int exp_gap;
		int i;
		while (got_addr.size() < exp_addr.size()) begin
			@(posedge clk);
		end
		repeat (idle_wait) @(posedge clk);
		if (got_addr.size() != exp_addr.size()) begin
			$display("Mismatch at %0t: run gave %0d downstream writes, expected %0d",
				$time, got_addr.size(), exp_addr.size());
			errors++;
		end
		for (i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
			check_write(got_addr[i], got_data[i], exp_addr[i], exp_data[i]);
			if (i > 0) begin
				exp_gap = 4 + (exp_delay[i-1] << `TGEN_GRAN);
				if (got_cyc[i] - got_cyc[i-1] != exp_gap) begin
					$display("Mismatch at %0t: write %0d came %0d cycles after the last, expected %0d",
						$time, i, got_cyc[i] - got_cyc[i-1], exp_gap);
					errors++;
				end
			end
		end
		if (coll_seen != clash_n) begin
			$display("Mismatch at %0t: collision pulsed %0d times during the run, expected %0d",
				$time, coll_seen, clash_n);
			errors++;
		end
		check_count(collision_count, r.exp_count);
		check_status(status, r.exp_status);
	endtask

	function automatic void add_row(int kind, tgen_pkg::lb_addr_t addr, tgen_pkg::lb_data_t data,
			int delay, tgen_pkg::status_t st, tgen_pkg::coll_count_t cnt);
		row_t r;
		r.kind = kind;
		r.addr = addr;
		r.data = data;
		r.delay = delay;
		r.exp_status = st;
		r.exp_count = cnt;
		rows.push_back(r);
	endfunction

	initial begin
		wait (wd_cycles > 0);
		#(wd_cycles * 20);
		$display("Run timed out after %0d cycles before the table was done", wd_cycles);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int err_before;
		seed = 32'hc791;
		errors = 0;
		arst_n = 1'b0;
		lb_data = '0;
		lb_addr = '0;
		lb_write = 1'b0;
		dests_write = 1'b0;
		addr_padding = 1'b1;
		trig = 1'b0;
		bank_next = 1'b0;

		// Trig and check rows carry bank_next in data and the expected status
		add_row(op_host, 17'h1_0040, 32'hdead_beef, 0, 4'b0000, 8'd0);
		add_row(op_dest, 17'h0_0123, 32'h0000_5a5a, 0, 4'b0000, 8'd0);
		add_row(op_entry, 17'h0010, '0, 3, 4'b0000, 8'd0);
		add_row(op_entry, 17'h0024, '0, 0, 4'b0000, 8'd0);
		add_row(op_entry, 17'h0abc, '0, 7, 4'b0000, 8'd0);
		add_row(op_entry, 17'h0000, '0, 2, 4'b0000, 8'd0);
		add_row(op_trig, '0, 32'd1, 0, 4'b0011, 8'd0);
		add_row(op_retrig, '0, '0, 0, 4'b0011, 8'd0);
		add_row(op_check, '0, '0, 0, 4'b0011, 8'd0);
		add_row(op_trig, '0, 32'd1, 0, 4'b1111, 8'd0);
		add_row(op_clash, 17'h1_8000, 32'h0bad_cafe, 0, 4'b1111, 8'd0);
		add_row(op_check, '0, '0, 0, 4'b1111, 8'd1);
		// Second program goes into the idle bank while the first one plays
		add_row(op_trig, '0, 32'd1, 0, 4'b1111, 8'd0);
		add_row(op_entry, 17'h0100, '0, 1, 4'b0000, 8'd0);
		add_row(op_entry, 17'h0200, '0, 5, 4'b0000, 8'd0);
		add_row(op_entry, 17'h0300, '0, 2, 4'b0000, 8'd0);
		add_row(op_entry, 17'h0000, '0, 0, 4'b0000, 8'd0);
		add_row(op_check, '0, '0, 0, 4'b1111, 8'd1);
		add_row(op_trig, '0, 32'd0, 0, 4'b1100, 8'd0);
		add_row(op_check, '0, '0, 0, 4'b1100, 8'd1);

		// Twice the summed row lengths and delays plus a margin
		wd_cycles = 100;
		foreach (rows[i]) begin
			wd_cycles += 2 * (8 + (rows[i].delay << `TGEN_GRAN));
			wd_cycles += (rows[i].kind == op_check) ? 2 * idle_wait : 0;
		end

		repeat (5) @(posedge clk);
		arst_n <= 1'b1;

		foreach (rows[i]) begin
			err_before = errors;
			case (rows[i].kind)
				op_host: host_write(rows[i], 1'b0);
				op_dest: host_write(rows[i], 1'b1);
				op_entry: load_entry(rows[i]);
				op_trig: start_run(rows[i]);
				op_retrig: retrigger_during_run(rows[i]);
				op_clash: clash_second_write(rows[i]);
				default: check_run(rows[i]);
			endcase
			$display("Test %0d kind %0d %s", i, rows[i].kind,
				(errors == err_before) ? "ok" : "with errors");
		end

		$display("Tests run %0d, errors %0d", rows.size(), errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
tgen_pkg.sv
program_ram.sv
tgen_sequencer.sv
bus_merge.sv
tgen_top.sv
tgen_tb.sv
